/* logic/deskew_cfg.svh */
`ifndef DESKEW_CFG_SVH
`define DESKEW_CFG_SVH

// Number of receive lanes, 20 for a full multi-lane link
`define DESKEW_N_LANES 4

// Payload width of one lane word
`define DESKEW_WORD_W 16

// First skew in beats that is rejected
`define DESKEW_MAX_SKEW 16

// One extra bit so that a count of DESKEW_MAX_SKEW itself fits
`define DESKEW_CNT_W ($clog2(`DESKEW_MAX_SKEW) + 1)

`endif

/* logic/deskew_pkg.sv */
`include "deskew_cfg.svh"

package deskew_pkg;

  // One lane beat as it travels through the deskew stage
  typedef struct packed {
    logic [`DESKEW_WORD_W-1:0] word;   // Lane payload
    logic                      marker; // Alignment marker seen on this beat
  } lane_beat_t;

  // Skew count and per-lane delay
  typedef logic [`DESKEW_CNT_W-1:0] skew_count_t;

  // One flag per lane
  typedef logic [`DESKEW_N_LANES-1:0] lane_mask_t;

  // Deskew controller states
  typedef enum logic [1:0] {
    INIT        = 2'd0,
    COUNT       = 2'd1,
    DESKEW_DONE = 2'd2
  } deskew_state_t;

endpackage

/* logic/deskew_fsm.sv */
`timescale 1ns/1ns
`include "deskew_cfg.svh"

module deskew_fsm
(
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  logic                    i_enable,
  input  logic                    i_resync,
  input  deskew_pkg::lane_mask_t  i_start_of_lane,
  input  deskew_pkg::skew_count_t i_common_counter,
  output logic                    o_enable_counters,
  output logic                    o_stop_common_counter,
  output logic                    o_set_fifo_delay,
  output deskew_pkg::lane_mask_t  o_stop_lane_counters,
  output logic                    o_align_status,
  output logic                    o_valid_skew
);

  import deskew_pkg::*;

  deskew_state_t state;
  deskew_state_t state_next;
  lane_mask_t    arrived;       // Sticky marker arrival per lane
  lane_mask_t    arrived_next;
  logic          align_status;
  logic          align_status_next;
  logic          valid_skew;
  logic          valid_skew_next;
  logic          invalid_skew;
  logic          all_arrived;

  assign invalid_skew = (i_common_counter >= skew_count_t'(`DESKEW_MAX_SKEW));
  assign all_arrived  = &arrived;

  // Resync restarts the search exactly like reset
  always_ff @(posedge i_clock)
  begin
    if (i_reset || i_resync)
    begin
      state        <= INIT;
      arrived      <= '0;
      align_status <= 1'b0;
      valid_skew   <= 1'b0;
    end
    else if (i_enable)
    begin
      state        <= state_next;
      arrived      <= arrived_next;
      align_status <= align_status_next;
      valid_skew   <= valid_skew_next;
    end
  end

  always_comb
  begin
    state_next            = state;
    arrived_next          = arrived;
    align_status_next     = 1'b0;
    valid_skew_next       = 1'b0;
    o_set_fifo_delay      = 1'b0;
    o_stop_common_counter = 1'b0;

    case (state)
      INIT:
      begin
        // First marker on any lane starts the measurement
        if (|i_start_of_lane)
        begin
          state_next   = COUNT;
          arrived_next = i_start_of_lane;
        end
      end

      COUNT:
      begin
        arrived_next = arrived | i_start_of_lane;
        if (invalid_skew)
        begin
          state_next   = INIT;        // Skew too large, start over
          arrived_next = '0;
        end
        else if (all_arrived)
        begin
          state_next            = DESKEW_DONE;
          align_status_next     = 1'b1;
          valid_skew_next       = 1'b1;
          o_set_fifo_delay      = i_enable; // Held to one clock across stalls
          o_stop_common_counter = i_enable;
        end
      end

      DESKEW_DONE:
      begin
        // Alignment holds until reset or resync
        align_status_next = 1'b1;
        valid_skew_next   = 1'b1;
      end

      default:
      begin
        state_next   = INIT;
        arrived_next = '0;
      end
    endcase
  end

  assign o_enable_counters    = (state == COUNT);
  assign o_stop_lane_counters = arrived;
  assign o_align_status       = align_status;
  assign o_valid_skew         = valid_skew;

endmodule

/* logic/skew_counters.sv */
`timescale 1ns/1ns
`include "deskew_cfg.svh"

module skew_counters
(
  input  logic                                            i_clock,
  input  logic                                            i_reset,
  input  logic                                            i_enable,
  input  logic                                            i_resync,
  input  logic                                            i_enable_counters,
  input  logic                                            i_stop_common_counter,
  input  deskew_pkg::lane_mask_t                          i_stop_lane_counters,
  output deskew_pkg::skew_count_t                         o_common_counter,
  output deskew_pkg::skew_count_t [`DESKEW_N_LANES-1:0]   o_lane_delay
);

  import deskew_pkg::*;

  localparam skew_count_t MAX_DELAY = skew_count_t'(`DESKEW_MAX_SKEW - 1);

  skew_count_t                         common_count;
  skew_count_t [`DESKEW_N_LANES-1:0]   lane_count;

  // Gap between the latest lane and this one, clamped to the delay line depth
  function automatic skew_count_t sat_delay(skew_count_t common, skew_count_t lane);
    skew_count_t diff;
    diff = common - lane;
    if (diff > MAX_DELAY)
      return MAX_DELAY;
    return diff;
  endfunction

  // Common counter ends up holding the largest skew
  always_ff @(posedge i_clock)
  begin
    if (i_reset || i_resync)
      common_count <= '0;
    else if (i_enable)
    begin
      if (!i_enable_counters)
        common_count <= '0;   // Idle, ready for the next measurement
      else if (!i_stop_common_counter)
        common_count <= common_count + skew_count_t'(1);
    end
  end

  // Each lane counts until its own marker has arrived
  always_ff @(posedge i_clock)
  begin
    if (i_reset || i_resync)
      lane_count <= '0;
    else if (i_enable)
    begin
      for (int lane = 0; lane < `DESKEW_N_LANES; lane++)
      begin
        if (!i_enable_counters)
          lane_count[lane] <= '0;
        else if (!i_stop_lane_counters[lane])
          lane_count[lane] <= lane_count[lane] + skew_count_t'(1);
      end
    end
  end

  always_comb
  begin
    for (int lane = 0; lane < `DESKEW_N_LANES; lane++)
      o_lane_delay[lane] = sat_delay(common_count, lane_count[lane]);
  end

  assign o_common_counter = common_count;

endmodule

/* logic/lane_delay_line.sv */
`timescale 1ns/1ns
`include "deskew_cfg.svh"

module lane_delay_line
(
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  logic                    i_enable,
  input  logic                    i_load,
  input  deskew_pkg::skew_count_t i_delay,
  input  deskew_pkg::lane_beat_t  i_beat,
  output deskew_pkg::lane_beat_t  o_beat
);

  import deskew_pkg::*;

  localparam int DEPTH = `DESKEW_MAX_SKEW;
  localparam int TAP_W = $clog2(DEPTH);

  lane_beat_t [DEPTH-1:0] taps;      // Entry 0 is the live input
  lane_beat_t [DEPTH-2:0] history;   // Older beats, newest at index 0
  logic [TAP_W-1:0]       tap_sel;

  assign taps = {history, i_beat};

  // Markers cleared so that stale entries never look like alignment
  always_ff @(posedge i_clock)
  begin
    if (i_reset)
    begin
      for (int k = 0; k < DEPTH - 1; k++)
        history[k].marker <= 1'b0;
    end
    else if (i_enable)
      history <= taps[DEPTH-2:0];
  end

  // Tap follows the delay computed at the end of the measurement
  always_ff @(posedge i_clock)
  begin
    if (i_reset)
      tap_sel <= '0;
    else if (i_enable && i_load)
    begin
      if (i_delay > skew_count_t'(DEPTH - 1))
        tap_sel <= TAP_W'(DEPTH - 1);
      else
        tap_sel <= i_delay[TAP_W-1:0];
    end
  end

  // Output register adds the fixed one beat of latency
  always_ff @(posedge i_clock)
  begin
    if (i_reset)
      o_beat.marker <= 1'b0;
    else if (i_enable)
      o_beat <= taps[tap_sel];
  end

endmodule

/* logic/lane_deskew_top.sv */
`timescale 1ns/1ns
`include "deskew_cfg.svh"

module lane_deskew_top
(
  input  logic                                           i_clock,
  input  logic                                           i_reset,
  input  logic                                           i_enable,
  input  logic                                           i_am_lock,
  input  logic                                           i_resync,
  input  deskew_pkg::lane_beat_t [`DESKEW_N_LANES-1:0]   i_lanes,
  output deskew_pkg::lane_beat_t [`DESKEW_N_LANES-1:0]   o_lanes,
  output logic                                           o_align_status,
  output logic                                           o_valid_skew
);

  import deskew_pkg::*;

  lane_mask_t                          start_of_lane;   // Qualified marker flags
  lane_mask_t                          stop_lane_counters;
  logic                                enable_counters;
  logic                                stop_common_counter;
  logic                                set_fifo_delay;
  skew_count_t                         common_counter;
  skew_count_t [`DESKEW_N_LANES-1:0]   lane_delay;

  // Markers only count while upstream marker lock is up
  always_comb
  begin
    for (int lane = 0; lane < `DESKEW_N_LANES; lane++)
      start_of_lane[lane] = i_lanes[lane].marker & i_enable & i_am_lock;
  end

  deskew_fsm deskew_fsm_i
  (
    .i_clock               (i_clock),
    .i_reset               (i_reset),
    .i_enable              (i_enable),
    .i_resync              (i_resync),
    .i_start_of_lane       (start_of_lane),
    .i_common_counter      (common_counter),
    .o_enable_counters     (enable_counters),
    .o_stop_common_counter (stop_common_counter),
    .o_set_fifo_delay      (set_fifo_delay),
    .o_stop_lane_counters  (stop_lane_counters),
    .o_align_status        (o_align_status),
    .o_valid_skew          (o_valid_skew)
  );

  skew_counters skew_counters_i
  (
    .i_clock               (i_clock),
    .i_reset               (i_reset),
    .i_enable              (i_enable),
    .i_resync              (i_resync),
    .i_enable_counters     (enable_counters),
    .i_stop_common_counter (stop_common_counter),
    .i_stop_lane_counters  (stop_lane_counters),
    .o_common_counter      (common_counter),
    .o_lane_delay          (lane_delay)
  );

  // One delay line per lane, all loaded by the same pulse
  for (genvar g = 0; g < `DESKEW_N_LANES; g++)
  begin : g_lane
    lane_delay_line lane_delay_line_i
    (
      .i_clock  (i_clock),
      .i_reset  (i_reset),
      .i_enable (i_enable),
      .i_load   (set_fifo_delay),
      .i_delay  (lane_delay[g]),
      .i_beat   (i_lanes[g]),
      .o_beat   (o_lanes[g])
    );
  end

endmodule

/* sim/deskew_asserts.sv */
`timescale 1ns/1ns

module deskew_asserts
(
  input logic                          i_clock,
  input logic                          i_reset,
  input logic                          i_resync,
  input logic                          i_set_fifo_delay,
  input deskew_pkg::deskew_state_t     i_state,
  input deskew_pkg::lane_mask_t        i_arrived
);

  import deskew_pkg::*;

  int fail_count = 0;   // Failed assertion count

  // Delay load is a single clock wide
  load_single_beat: assert property (@(posedge i_clock) disable iff (i_reset)
    i_set_fifo_delay |=> !i_set_fifo_delay)
    else
    begin
      $error("Delay load pulse lasted more than one clock");
      fail_count++;
    end

  state_known: assert property (@(posedge i_clock) disable iff (i_reset)
    !$isunknown(i_state) && (i_state inside {INIT, COUNT, DESKEW_DONE}))
    else
    begin
      $error("FSM state is unknown or illegal");
      fail_count++;
    end

  // Sticky arrival bits only grow while counting
  arrival_sticky: assert property (@(posedge i_clock) disable iff (i_reset)
    (i_state == COUNT && !i_resync) |=>
      (i_state != COUNT) || ((i_arrived & $past(i_arrived)) == $past(i_arrived)))
    else
    begin
      $error("Arrival mask lost a bit while counting");
      fail_count++;
    end

endmodule

/* sim/deskew_tb.sv */
`timescale 1ns/1ns
`include "deskew_cfg.svh"

module deskew_tb;

  import deskew_pkg::*;

  localparam int N_LANES = `DESKEW_N_LANES;
  localparam int WORD_W  = `DESKEW_WORD_W;
  localparam int HIST    = 4096;
  localparam int PERIOD  = 64;   // Marker spacing in beats

  logic                        i_clock;
  logic                        i_reset;
  logic                        i_enable;
  logic                        i_am_lock;
  logic                        i_resync;
  lane_beat_t [N_LANES-1:0]    i_lanes;
  lane_beat_t [N_LANES-1:0]    o_lanes;
  logic                        o_align_status;
  logic                        o_valid_skew;

  logic [31:0]                 rng_state;
  logic [WORD_W-1:0]           ref_word [HIST];
  int                          skew [N_LANES];
  int                          error_count;
  int                          assert_errors;
  int                          drv_n;        // Beat index of the driven data
  int                          drv_smax;
  logic                        drv_en;
  int                          cap_n;
  int                          cap_smax;
  logic                        cap_en;
  logic                        align_q;
  logic                        check_on;
  logic                        resync_req;
  logic                        lock_req;

  lane_deskew_top lane_deskew_top_i
  (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_enable       (i_enable),
    .i_am_lock      (i_am_lock),
    .i_resync       (i_resync),
    .i_lanes        (i_lanes),
    .o_lanes        (o_lanes),
    .o_align_status (o_align_status),
    .o_valid_skew   (o_valid_skew)
  );

  bind deskew_fsm deskew_asserts deskew_asserts_i
  (
    .i_clock          (i_clock),
    .i_reset          (i_reset),
    .i_resync         (i_resync),
    .i_set_fifo_delay (o_set_fifo_delay),
    .i_state          (state),
    .i_arrived        (arrived)
  );

  initial
  begin
    i_clock = 1'b0;
    forever #50 i_clock = ~i_clock;
  end

  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Reference beat, nothing before the stream starts
  function automatic lane_beat_t ref_beat(int idx);
    lane_beat_t b;
    b = '0;
    if (idx >= 0 && idx < HIST)
    begin
      b.word   = ref_word[idx];
      b.marker = (idx % PERIOD == 32);
    end
    return b;
  endfunction

  task automatic report(string name, logic [31:0] exp, logic [31:0] act);
    $display("ERROR %s expected %h actual %h", name, exp, act);
    error_count++;
  endtask

  task automatic set_skews(bit valid);
    drv_smax = 0;
    for (int l = 0; l < N_LANES; l++)
      skew[l] = next_rand() % `DESKEW_MAX_SKEW;
    if (!valid)
    begin
      skew[0] = 0;
      skew[1] = `DESKEW_MAX_SKEW + (next_rand() % 8);
    end
    for (int l = 0; l < N_LANES; l++)
      if (skew[l] > drv_smax)
        drv_smax = skew[l];
  endtask

  // One clock: drive on the rising edge, check on the falling edge
  task automatic step_cycle();
    logic [31:0]              r;
    lane_beat_t [N_LANES-1:0] nxt;
    lane_beat_t               exp;
    @(posedge i_clock);
    cap_en   = drv_en;
    cap_n    = drv_n;
    cap_smax = drv_smax;
    r        = next_rand();
    drv_en   = (r[2:0] != 3'd0);   // About one idle beat in eight
    if (drv_en)
    begin
      drv_n = drv_n + 1;
      for (int l = 0; l < N_LANES; l++)
        nxt[l] = ref_beat(drv_n - skew[l]);
    end
    else
    begin
      for (int l = 0; l < N_LANES; l++)
        nxt[l] = lane_beat_t'(next_rand());   // Junk, must be ignored
    end
    i_lanes    <= nxt;
    i_enable   <= drv_en;
    i_resync   <= resync_req;
    i_am_lock  <= lock_req;
    resync_req = 1'b0;
    @(negedge i_clock);
    if (check_on)
    begin
      assert (o_align_status)
      else
        report("stall_align", 1, o_align_status);
      assert (o_valid_skew)
      else
        report("stall_valid", 1, o_valid_skew);
      if (cap_en && align_q)
      begin
        exp = ref_beat(cap_n - cap_smax);
        for (int l = 0; l < N_LANES; l++)
        begin
          assert (o_lanes[l] == exp)
          else
            report($sformatf("content_lane%0d", l), exp, o_lanes[l]);
          assert (o_lanes[l] == o_lanes[0])
          else
            report($sformatf("equal_lane%0d", l), o_lanes[0], o_lanes[l]);
        end
      end
    end
    align_q = o_align_status;
  endtask

  task automatic run_beats(int count, bit expect_low, string name);
    int beats;
    int cycles;
    beats  = 0;
    cycles = 0;
    while (beats < count && cycles < count * 8 + 16)
    begin
      step_cycle();
      cycles++;
      if (cap_en)
        beats++;
      if (expect_low)
      begin
        assert (!o_align_status)
        else
          report(name, 0, o_align_status);
        assert (!o_valid_skew)
        else
          report({name, "_valid"}, 0, o_valid_skew);
      end
    end
    if (beats < count)
    begin
      $display("Timeout in %s, too few enabled beats", name);
      error_count++;
    end
  endtask

  // Stops once the next driven beat starts a marker period
  task automatic wait_boundary();
    int cycles;
    cycles = 0;
    while (((drv_n + 1) % PERIOD != 0 || !drv_en) && cycles < 1024)
    begin
      step_cycle();
      cycles++;
    end
    if (cycles >= 1024)
    begin
      $display("Timeout waiting for a marker period boundary");
      error_count++;
    end
  endtask

  task automatic wait_align(string name);
    int beats;
    int cycles;
    int limit;
    beats  = 0;
    cycles = 0;
    limit  = PERIOD + drv_smax;
    while (!o_align_status && beats <= limit && cycles < limit * 8)
    begin
      step_cycle();
      cycles++;
      if (cap_en)
        beats++;
    end
    if (!o_align_status)
    begin
      $display("Timeout in %s, alignment did not come up", name);
      error_count++;
    end
  endtask

  task automatic resync_pulse(string name);
    resync_req = 1'b1;
    step_cycle();
    step_cycle();
    assert (!o_align_status)
    else
      report(name, 0, o_align_status);
    assert (!o_valid_skew)
    else
      report({name, "_valid"}, 0, o_valid_skew);
  endtask

  initial
  begin
    rng_state   = 32'hdcd4_561f;
    error_count = 0;
    drv_n       = -1;
    drv_en      = 1'b0;
    drv_smax    = 0;
    align_q     = 1'b0;
    check_on    = 1'b0;
    resync_req  = 1'b0;
    lock_req    = 1'b0;
    i_reset     = 1'b1;
    i_enable    = 1'b0;
    i_am_lock   = 1'b0;
    i_resync    = 1'b0;
    i_lanes     = '0;
    for (int k = 0; k < HIST; k++)
      ref_word[k] = WORD_W'(next_rand());
    set_skews(1'b1);
    repeat (3) @(posedge i_clock);
    i_reset <= 1'b0;

    // No lock, no alignment
    run_beats(2 * PERIOD, 1'b1, "lock_low");
    wait_boundary();
    lock_req = 1'b1;
    wait_align("first_align");
    check_on = 1'b1;
    run_beats(300, 1'b0, "aligned_run");
    check_on = 1'b0;

    // One lane too late
    wait_boundary();
    set_skews(1'b0);
    resync_pulse("resync_drop");
    run_beats(2 * PERIOD, 1'b1, "invalid_skew");

    repeat (2)
    begin
      wait_boundary();
      set_skews(1'b1);
      resync_pulse("resync_drop");
      wait_align("realign");
      check_on = 1'b1;
      run_beats(200, 1'b0, "realigned_run");
      check_on = 1'b0;
    end

    assert_errors = lane_deskew_top_i.deskew_fsm_i.deskew_asserts_i.fail_count;
    $display("Errors: %0d in checks, %0d in assertions", error_count, assert_errors);
    if (error_count == 0 && assert_errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* all.f */
+incdir+logic
logic/deskew_pkg.sv
logic/deskew_fsm.sv
logic/skew_counters.sv
logic/lane_delay_line.sv
logic/lane_deskew_top.sv
sim/deskew_asserts.sv
sim/deskew_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= deskew_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  --Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
